/* design/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------

// Width of one bus word.
`define SOC_DATA_W 32

// --------------------------------------------------
// Memory map
// --------------------------------------------------

// Word address bits of the RAM, 2^14 words cover 64 KiB.
`define SOC_RAM_AW 14

// Upper half of the address for the RAM region.
`define SOC_RAM_REGION_HI 16'h0000

// LED register, the low two address bits are ignored.
`define SOC_LED_ADDR 32'h0001_0000

// --------------------------------------------------
// UART
// --------------------------------------------------

// Clock cycles per serial bit, kept short for simulation.
`define SOC_CLKS_PER_BIT 16

`endif

/* design/soc_pkg.sv */
`include "soc_defines.svh"

package soc_pkg;

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------

    // One bus data word.
    typedef logic [`SOC_DATA_W-1:0] bus_word_t;

    // LED register and UART payload.
    typedef logic [7:0] byte_t;

    // --------------------------------------------------
    // Bus access
    // --------------------------------------------------

    // One word access from the master.
    // An all-zero mask is a read.
    typedef struct packed {
        logic [31:0]              addr;
        bus_word_t                wdata;
        logic [`SOC_DATA_W/8-1:0] wmask;
    } bus_req_t;

    // Decoded target of an access.
    // At most one flag is set, none for an unmapped address.
    typedef struct packed {
        logic ram;
        logic leds;
    } region_sel_t;

endpackage

/* design/bus_decode.sv */
`timescale 1ns/100ps

`include "soc_defines.svh"

module bus_decode (
    input  logic                 pll_clk,
    input  logic                 rst,
    input  soc_pkg::bus_req_t    req,
    output soc_pkg::region_sel_t sel_now,
    output soc_pkg::region_sel_t sel_q
);
    import soc_pkg::*;

    localparam logic [31:0] LED_ADDR = `SOC_LED_ADDR;

    region_sel_t sel_d;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    always_comb begin
        sel_d = '0;
        // RAM takes the whole low 64 KiB.
        sel_d.ram = (req.addr[31:16] == `SOC_RAM_REGION_HI);
        // LED register is a single word, byte offset ignored.
        sel_d.leds = (req.addr[31:2] == LED_ADDR[31:2]);
    end

    assign sel_now = sel_d;

    // --------------------------------------------------
    // Return cycle select
    // --------------------------------------------------

    // Read data arrives one cycle after the address,
    // so the select is kept for steering it.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel_d;
        end
    end

endmodule

/* design/bus_ram.sv */
`timescale 1ns/100ps

`include "soc_defines.svh"

module bus_ram (
    input  logic               pll_clk,
    input  logic               sel,
    input  soc_pkg::bus_req_t  req,
    output soc_pkg::bus_word_t rdata
);
    import soc_pkg::*;

    localparam int DEPTH = 1 << `SOC_RAM_AW;
    localparam int LANES = $bits(bus_word_t) / 8;

    bus_word_t              mem [0:DEPTH-1];
    logic [`SOC_RAM_AW-1:0] word_addr;

    // Word index, byte offset dropped.
    assign word_addr = req.addr[`SOC_RAM_AW+1:2];

    // --------------------------------------------------
    // Byte lane writes
    // --------------------------------------------------

    always_ff @(posedge pll_clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (sel && req.wmask[i]) begin
                mem[word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
    end

    // --------------------------------------------------
    // Registered read
    // --------------------------------------------------

    // Reads every cycle.
    // A write in the same cycle is not seen until the next read.
    always_ff @(posedge pll_clk) begin
        rdata <= mem[word_addr];
    end

endmodule

/* design/bus_readback.sv */
`timescale 1ns/100ps

module bus_readback (
    input  logic                 pll_clk,
    input  logic                 rst,
    input  soc_pkg::bus_req_t    req,
    input  logic                 led_sel,
    input  soc_pkg::region_sel_t sel_q,
    input  soc_pkg::bus_word_t   ram_rdata,
    output soc_pkg::bus_word_t   rdata,
    output soc_pkg::byte_t       leds
);
    import soc_pkg::*;

    byte_t led_q;
    byte_t led_rd_q;

    // --------------------------------------------------
    // LED register
    // --------------------------------------------------

    // Only byte lane 0 reaches the LEDs.
    // The read copy lines up with the RAM read register.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            led_q    <= '0;
            led_rd_q <= '0;
        end else begin
            if (led_sel && req.wmask[0]) begin
                led_q <= req.wdata[7:0];
            end
            led_rd_q <= led_q;
        end
    end

    assign leds = led_q;

    // --------------------------------------------------
    // Read word merge
    // --------------------------------------------------

    // Each source is masked by its registered select.
    // Unmapped reads fall out as zero.
    always_comb begin
        rdata = '0;
        if (sel_q.ram) begin
            rdata = rdata | ram_rdata;
        end
        if (sel_q.leds) begin
            rdata = rdata | bus_word_t'(led_rd_q);
        end
    end

endmodule

/* design/uart_rx.sv */
`timescale 1ns/100ps

`include "soc_defines.svh"

module uart_rx (
    input  logic           pll_clk,
    input  logic           rst,
    input  logic           rx,
    output soc_pkg::byte_t rx_byte,
    output logic           rx_received
);
    import soc_pkg::*;

    localparam int CLKS  = `SOC_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    localparam logic [CNT_W-1:0] HALF_M1 = CNT_W'(CLKS / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_M1 = CNT_W'(CLKS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    byte_t            shift;

    // --------------------------------------------------
    // Input synchronizer
    // --------------------------------------------------

    // Idle line is high, so reset to one.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // --------------------------------------------------
    // Frame FSM
    // --------------------------------------------------

    always_ff @(posedge pll_clk) begin
        if (rst) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            rx_received <= 1'b0;
        end else begin
            rx_received <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck at mid start bit, a glitch goes back to idle.
                    if (cnt == HALF_M1) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == FULL_M1) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    // Strobe only on a high stop bit.
                    if (cnt == FULL_M1) begin
                        cnt         <= '0;
                        rx_received <= rx_sync;
                        state       <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Data shift register
    // --------------------------------------------------

    // LSB arrives first, shift in from the top.
    always_ff @(posedge pll_clk) begin
        if (state == RX_DATA && cnt == FULL_M1) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign rx_byte = shift;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/100ps

`include "soc_defines.svh"

module uart_tx (
    input  logic           pll_clk,
    input  logic           rst,
    input  logic           tx_start,
    input  soc_pkg::byte_t tx_byte,
    output logic           tx,
    output logic           tx_ready
);
    localparam int CLKS    = `SOC_CLKS_PER_BIT;
    localparam int CNT_W   = $clog2(CLKS);
    localparam int FRAME_W = $bits(tx_byte) + 2;

    localparam logic [CNT_W-1:0] FULL_M1  = CNT_W'(CLKS - 1);
    localparam logic [3:0]       LAST_BIT = 4'(FRAME_W - 1);

    logic               busy;
    logic [CNT_W-1:0]   cnt;
    logic [3:0]         bit_cnt;
    logic [FRAME_W-1:0] frame;

    // --------------------------------------------------
    // Frame shifter
    // --------------------------------------------------

    // Stop bit on top, start bit at the bottom.
    // Ones shift in behind the frame, so the line rests high.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            frame   <= '1;
        end else if (!busy) begin
            if (tx_start) begin
                busy    <= 1'b1;
                cnt     <= '0;
                bit_cnt <= '0;
                frame   <= {1'b1, tx_byte, 1'b0};
            end
        end else if (cnt == FULL_M1) begin
            cnt   <= '0;
            frame <= {1'b1, frame[FRAME_W-1:1]};
            if (bit_cnt == LAST_BIT) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------

    assign tx       = frame[0];
    assign tx_ready = !busy;

endmodule

/* design/soc_top.sv */
`timescale 1ns/100ps

module soc_top (
    input  logic               pll_clk,
    input  logic               rst,
    input  soc_pkg::bus_req_t  req,
    output soc_pkg::bus_word_t rdata,
    output soc_pkg::byte_t     leds,
    input  logic               uart_rx,
    output logic               uart_tx
);
    import soc_pkg::*;

    // Decoded target, now and in the return cycle.
    region_sel_t sel_now;
    region_sel_t sel_q;

    bus_word_t ram_rdata;

    // Echo path.
    byte_t rx_byte;
    logic  rx_received;
    logic  tx_ready;

    // --------------------------------------------------
    // Memory bus
    // --------------------------------------------------

    bus_decode bus_decode (
        .pll_clk (pll_clk),
        .rst     (rst),
        .req     (req),
        .sel_now (sel_now),
        .sel_q   (sel_q)
    );

    bus_ram bus_ram (
        .pll_clk (pll_clk),
        .sel     (sel_now.ram),
        .req     (req),
        .rdata   (ram_rdata)
    );

    bus_readback bus_readback (
        .pll_clk   (pll_clk),
        .rst       (rst),
        .req       (req),
        .led_sel   (sel_now.leds),
        .sel_q     (sel_q),
        .ram_rdata (ram_rdata),
        .rdata     (rdata),
        .leds      (leds)
    );

    // --------------------------------------------------
    // UART echo
    // --------------------------------------------------

    uart_rx receiver (
        .pll_clk     (pll_clk),
        .rst         (rst),
        .rx          (uart_rx),
        .rx_byte     (rx_byte),
        .rx_received (rx_received)
    );

    // A byte that arrives while busy is dropped.
    uart_tx transmitter (
        .pll_clk  (pll_clk),
        .rst      (rst),
        .tx_start (rx_received),
        .tx_byte  (rx_byte),
        .tx       (uart_tx),
        .tx_ready (tx_ready)
    );

endmodule

/* tests/soc_props.sv */
`timescale 1ns/100ps

module soc_props (
    input logic                 pll_clk,
    input logic                 rst,
    input soc_pkg::bus_req_t    req,
    input soc_pkg::region_sel_t sel_now,
    input soc_pkg::bus_word_t   rdata,
    input logic                 rx_received,
    input logic                 tx_ready,
    input logic                 uart_tx
);

    // Unmapped read returns zero in the next cycle.
    assert property (@(posedge pll_clk) disable iff (rst)
        (req.wmask == '0 && sel_now == '0) |=> (rdata == '0))
        else $error("rdata not zero after an unmapped read");

    // Idle transmitter holds the line high.
    assert property (@(posedge pll_clk) disable iff (rst) tx_ready |-> uart_tx)
        else $error("uart_tx low while tx_ready is high");

    // Received strobe lasts one cycle.
    assert property (@(posedge pll_clk) disable iff (rst) rx_received |=> !rx_received)
        else $error("rx_received high for two cycles in a row");

endmodule

bind soc_top soc_props props (
    .pll_clk     (pll_clk),
    .rst         (rst),
    .req         (req),
    .sel_now     (sel_now),
    .rdata       (rdata),
    .rx_received (rx_received),
    .tx_ready    (tx_ready),
    .uart_tx     (uart_tx)
);

/* tests/soc_tb.sv */
`timescale 1ns/100ps

`include "soc_defines.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int          CLKS    = `SOC_CLKS_PER_BIT;
    localparam logic [31:0] LED     = `SOC_LED_ADDR;
    localparam logic [31:0] NOWHERE = 32'hFFFF_FFF0;

    typedef enum logic {OP_WRITE, OP_READ} op_t;

    // One bus access and what the bus shows a cycle later.
    typedef struct packed {
        op_t       kind;
        bus_req_t  req;
        bus_word_t exp_rdata;
        byte_t     exp_leds;
    } entry_t;

    logic        pll_clk     = 1'b0;
    logic        rst;
    bus_req_t    req;
    bus_word_t   rdata;
    byte_t       leds;
    logic        rx;
    logic        tx;
    logic        table_ready = 1'b0;
    logic [15:0] lfsr        = 16'd70;
    entry_t      ops[$];
    bus_word_t   ram_model[int];
    byte_t       led_model   = '0;

    soc_top UUT (
        .pll_clk (pll_clk),
        .rst     (rst),
        .req     (req),
        .rdata   (rdata),
        .leds    (leds),
        .uart_rx (rx),
        .uart_tx (tx)
    );

    always #5 pll_clk = ~pll_clk;

    // --------------------------------------------------
    // Random data and expected values
    // --------------------------------------------------

    // Galois LFSR stepped once per bit taken.
    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic bus_word_t rand_word(input int bits);
        bus_word_t w;
        w = '0;
        for (int i = 0; i < bits; i++) begin
            w = {w[30:0], rand_bit()};
        end
        return w;
    endfunction

    // Applies the memory map to the model and queues the access.
    task automatic add_op(input logic [31:0] addr, input logic [3:0] mask, input bus_word_t wdata);
        entry_t e;
        int     idx;
        idx         = int'(addr[`SOC_RAM_AW+1:2]);
        e.kind      = (mask == '0) ? OP_READ : OP_WRITE;
        e.req       = '{addr: addr, wdata: wdata, wmask: mask};
        e.exp_rdata = '0;
        if (addr[31:16] == `SOC_RAM_REGION_HI) begin
            for (int l = 0; l < 4; l++) begin
                if (mask[l]) begin
                    ram_model[idx][8*l +: 8] = wdata[8*l +: 8];
                end
            end
            if (mask == '0) begin
                e.exp_rdata = ram_model[idx];
            end
        end else if (addr[31:2] == LED[31:2]) begin
            if (mask[0]) begin
                led_model = wdata[7:0];
            end
            e.exp_rdata = bus_word_t'(led_model);
        end
        e.exp_leds = led_model;
        ops.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] addrs [5] = '{32'h0, 32'h4, 32'h100, 32'h7FFC, 32'hFFFC};
        logic [3:0]  masks [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        foreach (addrs[i]) begin
            add_op(addrs[i], 4'hF, rand_word(32));
            add_op(addrs[i], 4'h0, '0);
        end
        // Back-to-back reads in reverse order.
        for (int i = 4; i >= 0; i--) begin
            add_op(addrs[i], 4'h0, '0);
        end
        foreach (masks[i]) begin
            add_op(32'h4, masks[i], rand_word(32));
            add_op(32'h4, 4'h0, '0);
        end
        // Unmapped write must not alias onto word 0.
        add_op(32'h0002_0000, 4'hF, rand_word(32));
        add_op(32'h0, 4'h0, '0);
        add_op(32'h0001_0004, 4'h0, '0);
        add_op(32'h8000_0000, 4'h0, '0);
        add_op(LED, 4'h1, rand_word(32));
        add_op(LED, 4'h0, '0);
        add_op(LED, 4'hE, rand_word(32));
        add_op(LED + 32'd3, 4'h0, '0);
        add_op(LED + 32'd2, 4'h1, rand_word(32));
        add_op(LED, 4'h0, '0);
        add_op(32'h100, 4'h0, '0);
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_now(input string what);
        $display("%0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_leds(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // Serial line
    // --------------------------------------------------

    // Starts and ends on a falling edge.
    task automatic send_serial(input byte_t b, input int stop_clks);
        rx = 1'b0;
        repeat (CLKS) @(negedge pll_clk);
        for (int k = 0; k < 8; k++) begin
            rx = b[k];
            repeat (CLKS) @(negedge pll_clk);
        end
        rx = 1'b1;
        repeat (stop_clks) @(negedge pll_clk);
    endtask

    // Samples each bit near its middle.
    task automatic read_tx_frame(output byte_t b);
        int waited;
        waited = 0;
        b      = '0;
        while (tx !== 1'b0) begin
            @(negedge pll_clk);
            waited++;
            if (waited > 20 * CLKS) begin
                fail_now("no start bit appeared on uart_tx");
            end
        end
        repeat (CLKS / 2) @(negedge pll_clk);
        if (tx !== 1'b0) begin
            fail_now("uart_tx start bit ended early");
        end
        for (int k = 0; k < 8; k++) begin
            repeat (CLKS) @(negedge pll_clk);
            b[k] = tx;
        end
        repeat (CLKS) @(negedge pll_clk);
        if (tx !== 1'b1) begin
            fail_now("uart_tx stop bit was low");
        end
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------

    initial begin
        byte_t got;
        byte_t sent;
        rst = 1'b1;
        rx  = 1'b1;
        // A RAM read stays on the bus through reset.
        req = '{addr: 32'h0, wdata: '0, wmask: '0};
        build_table();
        table_ready = 1'b1;
        repeat (3) @(negedge pll_clk);
        rst = 1'b0;
        check_word("rdata", rdata, '0);
        check_leds("leds", leds, '0);
        check_bit("uart_tx", tx, 1'b1);

        // One access per cycle with the result checked on the next falling edge.
        foreach (ops[i]) begin
            req = ops[i].req;
            @(negedge pll_clk);
            if (ops[i].kind == OP_READ) begin
                check_word($sformatf("rdata at %h", ops[i].req.addr), rdata, ops[i].exp_rdata);
            end
            check_leds("leds", leds, ops[i].exp_leds);
        end
        req = '{addr: NOWHERE, wdata: '0, wmask: '0};

        repeat (2) begin
            sent = byte_t'(rand_word(8));
            fork
                send_serial(sent, CLKS);
                read_tx_frame(got);
            join
            check_byte("uart_tx frame", got, sent);
        end

        // A short stop bit lands the second byte while the echo is going out.
        sent = byte_t'(rand_word(8));
        fork
            begin
                send_serial(sent, CLKS * 3 / 4);
                send_serial(~sent, CLKS);
            end
            read_tx_frame(got);
        join
        check_byte("uart_tx frame", got, sent);
        repeat (12 * CLKS) begin
            @(negedge pll_clk);
            if (tx !== 1'b1) begin
                fail_now("a byte sent while uart_tx was busy was echoed");
            end
        end
        $display("No errors");
        $finish;
    end

    // Bus table plus eight frame times and some slack.
    initial begin
        int limit;
        wait (table_ready);
        limit = ops.size() + 8 * 10 * CLKS + 64;
        #(limit * 10);
        fail_now("watchdog timeout, the run did not finish");
    end

endmodule

/* files.f */
+incdir+design
design/soc_pkg.sv
design/bus_decode.sv
design/bus_ram.sv
design/bus_readback.sv
design/uart_rx.sv
design/uart_tx.sv
design/soc_top.sv
tests/soc_props.sv
tests/soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := soc_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/soc_defines.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
